/* weight_rotator_pkg.sv */
// weight rotator shared sizes, header layout and the two views of an input word
`default_nettype none

package weight_rotator_pkg;

  // output row geometry
  localparam int COLS       = 4;
  localparam int WORD_WIDTH = 8;
  localparam int ROW_WIDTH  = COLS * WORD_WIDTH;

  // header field widths
  localparam int BITS_ADDR_MAX = 8;
  localparam int BITS_XN       = 4;
  localparam int BITS_COLS     = 6;
  localparam int BITS_CIN      = 6;
  localparam int BITS_KW2      = 2;
  // tap counter runs up to 2*kw2
  localparam int BITS_KW       = BITS_KW2 + 1;

  localparam int BITS_HEADER = BITS_ADDR_MAX + BITS_XN + BITS_COLS + BITS_CIN + BITS_KW2;

  // loop limits with kw2 in the lowest bits
  typedef struct packed {
    logic [ROW_WIDTH-BITS_HEADER-1:0] pad;
    logic [BITS_ADDR_MAX-1:0]         addr_max;
    logic [BITS_XN-1:0]               xn_1;
    logic [BITS_COLS-1:0]             cols_1;
    logic [BITS_CIN-1:0]              cin_1;
    logic [BITS_KW2-1:0]              kw2;
  } header_t;

  typedef logic [COLS-1:0][WORD_WIDTH-1:0] row_t;

  // first beat of a packet is a header and the rest are weight rows
  typedef union packed {
    header_t header;
    row_t    row;
  } in_word_u;

endpackage

`default_nettype wire

/* header_decode.sv */
// weight rotator write side that parses packet headers and fills the free bank
`timescale 1ns/1ps
`default_nettype none

module header_decode #(
  parameter  int DEPTH = 64,
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                              aclk,
  input  logic                              aresetn,
  input  logic                              i_valid,
  input  logic                              i_last,
  input  weight_rotator_pkg::in_word_u      i_data,
  input  logic                              i_release,
  input  logic                              i_release_bank,
  output logic                              o_ready,
  output logic                              o_wen,
  output logic                              o_wbank,
  output logic [AW-1:0]                     o_waddr,
  output logic [1:0]                        o_full,
  output weight_rotator_pkg::header_t [1:0] o_limits
);
  import weight_rotator_pkg::*;

  typedef enum logic [1:0] {IDLE, HEADER, WRITE, SWITCH} state_t;

  state_t  state;
  header_t hdr;
  logic    handshake;

  assign hdr       = i_data.header;
  assign o_ready   = (state == HEADER) || (state == WRITE);
  assign handshake = i_valid && o_ready;
  assign o_wen     = handshake && (state == WRITE);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= IDLE;
      o_wbank <= 1'b0;
      o_waddr <= '0;
      o_full  <= 2'b00;
    end else begin
      // reader hands a drained bank back
      if (i_release) begin
        o_full[i_release_bank] <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (!o_full[o_wbank]) begin
            state <= HEADER;
          end
        end
        HEADER: begin
          if (handshake) begin
            o_waddr <= '0;
            state   <= WRITE;
          end
        end
        WRITE: begin
          if (handshake) begin
            o_waddr <= o_waddr + 1'b1;
            // hand the bank to the reader once the packet is done
            if (i_last) begin
              o_full[o_wbank] <= 1'b1;
              o_wbank         <= ~o_wbank;
              state           <= SWITCH;
            end
          end
        end
        SWITCH: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // limits of the bank being filled
  always_ff @(posedge aclk) begin
    if ((state == HEADER) && handshake) begin
      o_limits[o_wbank] <= hdr;
    end
  end

endmodule

`default_nettype wire

/* weight_bank.sv */
// weight rotator storage of two ram banks with a shared write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

module weight_bank #(
  parameter  int DEPTH = 64,
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                     aclk,
  input  logic                     i_wen,
  input  logic                     i_wbank,
  input  logic [AW-1:0]            i_waddr,
  input  weight_rotator_pkg::row_t i_wdata,
  input  logic                     i_ren,
  input  logic                     i_rbank,
  input  logic [AW-1:0]            i_raddr,
  output weight_rotator_pkg::row_t o_rdata
);
  import weight_rotator_pkg::*;

  // indexed by bank and then by row address
  row_t mem [2][DEPTH];

  always_ff @(posedge aclk) begin
    if (i_wen) begin
      mem[i_wbank][i_waddr] <= i_wdata;
    end
  end

  // one cycle read latency
  always_ff @(posedge aclk) begin
    if (i_ren) begin
      o_rdata <= mem[i_rbank][i_raddr];
    end
  end

endmodule

`default_nettype wire

/* read_sequencer.sv */
// weight rotator read side that replays a full bank with nested loop counters and position flags
`timescale 1ns/1ps
`default_nettype none

module read_sequencer #(
  parameter  int DEPTH = 64,
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                              aclk,
  input  logic                              aresetn,
  input  logic [1:0]                        i_full,
  input  weight_rotator_pkg::header_t [1:0] i_limits,
  input  logic                              i_space,
  output logic                              o_ren,
  output logic                              o_rbank,
  output logic [AW-1:0]                     o_raddr,
  output logic                              o_last,
  output logic                              o_first_clk,
  output logic                              o_cin_last,
  output logic                              o_w_last,
  output logic                              o_w_first_kw2,
  output logic                              o_release,
  output logic                              o_release_bank
);
  import weight_rotator_pkg::*;

  typedef enum logic [1:0] {IDLE, READ, SWITCH} state_t;

  state_t               state;
  header_t              lim;
  logic [AW-1:0]        addr;
  logic [BITS_KW-1:0]   c_kw;
  logic [BITS_CIN-1:0]  c_cin;
  logic [BITS_COLS-1:0] c_cols;
  logic [BITS_XN-1:0]   c_xn;
  logic [BITS_KW-1:0]   kw_max;
  logic [BITS_COLS-1:0] cols_left;
  logic                 l_addr;
  logic                 l_kw;
  logic                 l_cin;
  logic                 l_cols;
  logic                 l_xn;

  assign lim       = i_limits[o_rbank];
  // 2*kw2 taps past the first
  assign kw_max    = {lim.kw2, 1'b0};
  assign cols_left = lim.cols_1 - c_cols;

  assign l_addr = (BITS_ADDR_MAX'(addr) == lim.addr_max);
  assign l_kw   = (c_kw == kw_max);
  assign l_cin  = (c_cin == lim.cin_1);
  assign l_cols = (c_cols == lim.cols_1);
  assign l_xn   = (c_xn == lim.xn_1);

  assign o_ren         = (state == READ) && i_space;
  assign o_raddr       = addr;
  assign o_first_clk   = (c_kw == '0) && (c_cin == '0) && (c_cols == '0);
  assign o_cin_last    = l_kw && l_cin;
  assign o_w_last      = l_cols;
  assign o_w_first_kw2 = cols_left < BITS_COLS'(lim.kw2);
  assign o_last        = l_kw && l_cin && l_cols && l_xn;

  // index already points past the drained bank
  assign o_release      = (state == SWITCH);
  assign o_release_bank = ~o_rbank;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= IDLE;
      o_rbank <= 1'b0;
      addr    <= '0;
      c_kw    <= '0;
      c_cin   <= '0;
      c_cols  <= '0;
      c_xn    <= '0;
    end else begin
      case (state)
        IDLE: begin
          addr   <= '0;
          c_kw   <= '0;
          c_cin  <= '0;
          c_cols <= '0;
          c_xn   <= '0;
          if (i_full[o_rbank]) begin
            state <= READ;
          end
        end
        READ: begin
          if (o_ren) begin
            // address wraps independent of the loop nest
            addr <= l_addr ? '0 : addr + 1'b1;
            c_kw <= l_kw ? '0 : c_kw + 1'b1;
            if (l_kw) begin
              c_cin <= l_cin ? '0 : c_cin + 1'b1;
            end
            if (l_kw && l_cin) begin
              c_cols <= l_cols ? '0 : c_cols + 1'b1;
            end
            if (l_kw && l_cin && l_cols) begin
              c_xn <= l_xn ? '0 : c_xn + 1'b1;
            end
            if (o_last) begin
              o_rbank <= ~o_rbank;
              state   <= SWITCH;
            end
          end
        end
        SWITCH: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* output_buffer.sv */
// weight rotator output stage with a two-entry fifo that lines flags up with ram data
`timescale 1ns/1ps
`default_nettype none

module output_buffer (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     i_ren,
  input  weight_rotator_pkg::row_t i_rdata,
  input  logic                     i_last,
  input  logic                     i_first_clk,
  input  logic                     i_cin_last,
  input  logic                     i_w_last,
  input  logic                     i_w_first_kw2,
  input  logic                     i_ready,
  output logic                     o_space,
  output logic                     o_valid,
  output weight_rotator_pkg::row_t o_data,
  output logic                     o_last,
  output logic                     o_first_clk,
  output logic                     o_cin_last,
  output logic                     o_w_last,
  output logic                     o_w_first_kw2
);
  import weight_rotator_pkg::*;

  localparam int NFLAGS = 5;

  logic              pend;
  logic [NFLAGS-1:0] flags_d;
  row_t              buf_data [2];
  logic [NFLAGS-1:0] buf_flags [2];
  logic              wr_ptr;
  logic              rd_ptr;
  logic [1:0]        count;
  logic              pop;

  assign o_valid = (count != 2'd0);
  assign pop     = o_valid && i_ready;
  // a read in flight already owns a slot and a pop this cycle frees one
  assign o_space = (3'(count) + 3'(pend)) < (3'd2 + 3'(pop));

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pend <= 1'b0;
    end else begin
      pend <= i_ren;
    end
  end

  // flags wait one cycle for the ram data
  always_ff @(posedge aclk) begin
    if (i_ren) begin
      flags_d <= {i_last, i_first_clk, i_cin_last, i_w_last, i_w_first_kw2};
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (pend) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, pend} - {1'b0, pop};
    end
  end

  always_ff @(posedge aclk) begin
    if (pend) begin
      buf_data[wr_ptr]  <= i_rdata;
      buf_flags[wr_ptr] <= flags_d;
    end
  end

  // head entry stays put until it is taken
  assign o_data = buf_data[rd_ptr];
  assign {o_last, o_first_clk, o_cin_last, o_w_last, o_w_first_kw2} = buf_flags[rd_ptr];

endmodule

`default_nettype wire

/* weight_rotator.sv */
// weight rotator top with double-buffered weight storage replayed as a rotating row stream
`timescale 1ns/1ps
`default_nettype none

module weight_rotator #(
  parameter  int DEPTH = 64,
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                                     aclk,
  input  logic                                     aresetn,
  input  logic                                     i_valid,
  output logic                                     o_ready,
  input  logic [weight_rotator_pkg::ROW_WIDTH-1:0] i_data,
  input  logic                                     i_last,
  output logic                                     o_valid,
  input  logic                                     i_ready,
  output weight_rotator_pkg::row_t                 o_data,
  output logic                                     o_last,
  output logic                                     o_first_clk,
  output logic                                     o_cin_last,
  output logic                                     o_w_last,
  output logic                                     o_w_first_kw2
);
  import weight_rotator_pkg::*;

  in_word_u      in_word;
  header_t [1:0] limits;
  row_t          rdata;
  logic          wen;
  logic          wbank;
  logic [AW-1:0] waddr;
  logic [1:0]    full;
  logic          ren;
  logic          rbank;
  logic [AW-1:0] raddr;
  logic          rd_last;
  logic          rd_first_clk;
  logic          rd_cin_last;
  logic          rd_w_last;
  logic          rd_w_first_kw2;
  logic          space;
  logic          rel;
  logic          rel_bank;

  assign in_word = i_data;

  header_decode #(.DEPTH(DEPTH)) u_header_decode (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .i_valid        (i_valid),
    .i_last         (i_last),
    .i_data         (in_word),
    .i_release      (rel),
    .i_release_bank (rel_bank),
    .o_ready        (o_ready),
    .o_wen          (wen),
    .o_wbank        (wbank),
    .o_waddr        (waddr),
    .o_full         (full),
    .o_limits       (limits)
  );

  // weight beats are written as a full row
  weight_bank #(.DEPTH(DEPTH)) u_weight_bank (
    .aclk    (aclk),
    .i_wen   (wen),
    .i_wbank (wbank),
    .i_waddr (waddr),
    .i_wdata (in_word.row),
    .i_ren   (ren),
    .i_rbank (rbank),
    .i_raddr (raddr),
    .o_rdata (rdata)
  );

  read_sequencer #(.DEPTH(DEPTH)) u_read_sequencer (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .i_full         (full),
    .i_limits       (limits),
    .i_space        (space),
    .o_ren          (ren),
    .o_rbank        (rbank),
    .o_raddr        (raddr),
    .o_last         (rd_last),
    .o_first_clk    (rd_first_clk),
    .o_cin_last     (rd_cin_last),
    .o_w_last       (rd_w_last),
    .o_w_first_kw2  (rd_w_first_kw2),
    .o_release      (rel),
    .o_release_bank (rel_bank)
  );

  output_buffer u_output_buffer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_ren         (ren),
    .i_rdata       (rdata),
    .i_last        (rd_last),
    .i_first_clk   (rd_first_clk),
    .i_cin_last    (rd_cin_last),
    .i_w_last      (rd_w_last),
    .i_w_first_kw2 (rd_w_first_kw2),
    .i_ready       (i_ready),
    .o_space       (space),
    .o_valid       (o_valid),
    .o_data        (o_data),
    .o_last        (o_last),
    .o_first_clk   (o_first_clk),
    .o_cin_last    (o_cin_last),
    .o_w_last      (o_w_last),
    .o_w_first_kw2 (o_w_first_kw2)
  );

endmodule

`default_nettype wire

/* tb_weight_rotator.sv */
// weight rotator testbench that replays case packets and checks each beat against a loop model
`timescale 1ns/1ps
`default_nettype none

module tb_weight_rotator;
  import weight_rotator_pkg::*;

  localparam int          DEPTH = 64;
  localparam int          LIMIT = 2000;
  localparam logic [31:0] SEED  = 32'h949a_d3c5;

  logic                 aclk;
  logic                 aresetn;
  logic                 i_valid;
  logic                 o_ready;
  logic [ROW_WIDTH-1:0] i_data;
  logic                 i_last;
  logic                 o_valid;
  logic                 i_ready;
  row_t                 o_data;
  logic                 o_last;
  logic                 o_first_clk;
  logic                 o_cin_last;
  logic                 o_w_last;
  logic                 o_w_first_kw2;

  // two packets per case go to alternate banks
  row_t  rows [2][DEPTH];
  string tname;
  int    kw2;
  int    cin_1;
  int    cols_1;
  int    xn_1;
  int    addr_max;
  int    total;
  int    stall_pct;
  int    errors;
  int    tests;
  int    fails;
  int    done_b_cyc;
  int    last_a_cyc;
  int    cyc = 0;
  logic  timed_out;

  weight_rotator #(.DEPTH(DEPTH)) DUT (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_valid       (i_valid),
    .o_ready       (o_ready),
    .i_data        (i_data),
    .i_last        (i_last),
    .o_valid       (o_valid),
    .i_ready       (i_ready),
    .o_data        (o_data),
    .o_last        (o_last),
    .o_first_clk   (o_first_clk),
    .o_cin_last    (o_cin_last),
    .o_w_last      (o_w_last),
    .o_w_first_kw2 (o_w_first_kw2)
  );

  always #10 aclk = ~aclk;

  always @(posedge aclk) begin
    cyc <= cyc + 1;
  end

  // flags of beat n from the tap, channel, column, image nest
  function automatic logic [4:0] expect_flags(input int n);
    int taps;
    int t;
    int c;
    int w;
    taps = 2 * kw2 + 1;
    t = n % taps;
    c = (n / taps) % (cin_1 + 1);
    w = (n / (taps * (cin_1 + 1))) % (cols_1 + 1);
    expect_flags[4] = (n == total - 1);
    expect_flags[3] = (t == 0) && (c == 0) && (w == 0);
    expect_flags[2] = (t == 2 * kw2) && (c == cin_1);
    expect_flags[1] = (w == cols_1);
    expect_flags[0] = (cols_1 - w) < kw2;
  endfunction

  task automatic send_beat(input logic [ROW_WIDTH-1:0] data, input logic last);
    int waited;
    waited = 0;
    @(negedge aclk);
    i_valid = 1'b1;
    i_data  = data;
    i_last  = last;
    while (!o_ready && waited < LIMIT) begin
      @(negedge aclk);
      waited++;
    end
    if (!o_ready) begin
      $display("%0s timed out waiting for o_ready", tname);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic send_packet(input int p);
    header_t hdr;
    int      a;
    hdr          = '0;
    hdr.kw2      = BITS_KW2'(kw2);
    hdr.cin_1    = BITS_CIN'(cin_1);
    hdr.cols_1   = BITS_COLS'(cols_1);
    hdr.xn_1     = BITS_XN'(xn_1);
    hdr.addr_max = BITS_ADDR_MAX'(addr_max);
    send_beat(hdr, 1'b0);
    for (a = 0; a <= addr_max && !timed_out; a++) begin
      send_beat(rows[p][a], a == addr_max);
    end
    // last handshake lands on the coming rising edge
    if (p == 1) begin
      done_b_cyc = cyc + 1;
    end
    @(negedge aclk);
    i_valid = 1'b0;
    i_last  = 1'b0;
  endtask

  task automatic collect_packet(input int p);
    int                   n;
    int                   waited;
    logic                 held;
    logic [ROW_WIDTH+4:0] held_word;
    logic [ROW_WIDTH+4:0] now_word;
    row_t                 exp_row;
    logic [4:0]           exp_flags;
    n = 0;
    waited = 0;
    held = 1'b0;
    held_word = '0;
    while (n < total && !timed_out) begin
      @(negedge aclk);
      now_word = {o_data, o_last, o_first_clk, o_cin_last, o_w_last, o_w_first_kw2};
      // a stalled beat must come back unchanged
      if (held && (!o_valid || now_word != held_word)) begin
        $display("mismatch %0s beat %0d held, expected %h actual %h",
                 tname, n, held_word, now_word);
        errors++;
      end
      i_ready = ($urandom % 100) >= stall_pct;
      held = 1'b0;
      if (o_valid && i_ready) begin
        exp_row   = rows[p][n % (addr_max + 1)];
        exp_flags = expect_flags(n);
        if (o_data != exp_row) begin
          $display("mismatch %0s beat %0d data, expected %h actual %h",
                   tname, n, exp_row, o_data);
          errors++;
        end
        if (now_word[4:0] != exp_flags) begin
          $display("mismatch %0s beat %0d flags, expected %b actual %b",
                   tname, n, exp_flags, now_word[4:0]);
          errors++;
        end
        if (p == 0 && n == total - 1) begin
          last_a_cyc = cyc + 1;
        end
        n++;
        waited = 0;
      end else begin
        held      = o_valid;
        held_word = now_word;
        waited++;
        if (waited == LIMIT) begin
          $display("%0s timed out waiting for output beat %0d of packet %0d", tname, n, p);
          errors++;
          timed_out = 1'b1;
        end
      end
    end
  endtask

  task automatic run_case();
    int err_before;
    int p;
    int a;
    err_before = errors;
    total      = (2 * kw2 + 1) * (cin_1 + 1) * (cols_1 + 1) * (xn_1 + 1);
    stall_pct  = ($urandom % 3) * 25;
    for (p = 0; p < 2; p++) begin
      for (a = 0; a < DEPTH; a++) begin
        rows[p][a] = $urandom;
      end
    end
    done_b_cyc = 0;
    last_a_cyc = 0;
    fork
      begin
        send_packet(0);
        send_packet(1);
      end
      begin
        collect_packet(0);
        collect_packet(1);
      end
    join
    // long replays leave room to fill the other bank
    if (!timed_out && total > addr_max + 4 && done_b_cyc >= last_a_cyc) begin
      $display("%0s second packet was not accepted before the first finished reading", tname);
      errors++;
    end
    i_ready = 1'b1;
    repeat (4) begin
      @(negedge aclk);
      if (!timed_out && o_valid) begin
        $display("%0s output beat appeared after the expected count", tname);
        errors++;
      end
    end
    tests++;
    if (errors != err_before) begin
      fails++;
    end
    $display("%-14s %0s, %0d beats per packet, stall %0d%%", tname,
             (errors == err_before) ? "ok" : "failed", total, stall_pct);
  endtask

  initial begin
    int    fd;
    int    rc;
    string line;
    aclk      = 1'b0;
    aresetn   = 1'b0;
    i_valid   = 1'b0;
    i_data    = '0;
    i_last    = 1'b0;
    i_ready   = 1'b0;
    errors    = 0;
    tests     = 0;
    fails     = 0;
    timed_out = 1'b0;
    void'($urandom(SEED));
    repeat (16) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    if (o_valid) begin
      $display("o_valid is high right after reset");
      errors++;
    end
    fd = $fopen("weight_rotator_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open weight_rotator_cases.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        rc = $fgets(line, fd);
        // comment and blank lines do not scan to six fields
        if (rc > 0 && $sscanf(line, "%s %d %d %d %d %d", tname, kw2, cin_1, cols_1, xn_1,
                              addr_max) == 6) begin
          run_case();
        end
      end
      $fclose(fd);
    end
    $display("tests %0d, failed %0d, errors %0d", tests, fails, errors);
    if (errors == 0 && tests > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* weight_rotator_cases.txt */
# name kw2 cin_1 cols_1 xn_1 addr_max
# header fields in decimal, one test per line, addr_max below 64
single_tap    0 0 0 0 0
kw0_small     0 1 2 0 3
kw1_basic     1 0 3 0 4
kw2_basic     2 1 4 1 7
addr_zero     1 2 1 0 0
cin_wide      1 5 1 0 9
cols_wide     0 0 15 1 5
images        1 1 2 3 11
kw2_narrow    2 0 1 0 2
full_depth    1 1 3 0 63
deep_long     2 3 5 1 63
long_wrap     2 2 7 0 20
tiny_addr     0 3 3 3 1
odd_mix       1 3 0 2 6
max_kw        2 7 3 0 13
kw1_cols_one  1 2 0 1 30
kw2_zero_addr 2 1 2 0 0
short_replay  0 0 1 0 40

/* sim.f */
weight_rotator_pkg.sv
header_decode.sv
weight_bank.sv
read_sequencer.sv
output_buffer.sv
weight_rotator.sv
tb_weight_rotator.sv

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run from the project root, decide pass by the log
cd "$(dirname "$0")" &&
  verilator --binary -j 0 -f sim.f --top-module tb_weight_rotator -o sim_weight_rotator &&
  ./obj_dir/sim_weight_rotator | tee sim.log &&
  grep -qx "PASS: all tests" sim.log ||
  {
    echo "simulation did not pass"
    exit 1
  }
